/* dv/tb_z80_datapath.sv */
`timescale 1ns/1ns

module tb_z80_datapath;

  localparam int RESET_CYCLES = 16;
  // one read per main register, then A, then F
  localparam int RESET_READS  = z80_dp_pkg::NUM_MAIN_REGS + 2;
  localparam int RAND_CYCLES  = 2000;
  // half again the length of the whole run as margin
  localparam int MAX_CYCLES   = (RESET_CYCLES + RESET_READS + RAND_CYCLES) * 3 / 2;

  logic clk, rst, ld_reg, drive_reg, drive_pair, exx;
  logic ld_a, drive_a, ld_f, drive_f, alu_to_a, alu_to_reg, data_oe, addr_oe;
  z80_dp_pkg::byte_t data_in, data_out, flag_set, flag_clr;
  z80_dp_pkg::word_t addr_out;
  z80_dp_pkg::reg_code_t wr_code, rd_code;
  z80_dp_pkg::pair_code_t pair_code;
  z80_dp_pkg::alu_op_t alu_op;

  int seed = 83;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  // reference state: main and shadow banks, accumulator and flags
  z80_dp_pkg::byte_t m_main   [z80_dp_pkg::NUM_MAIN_REGS];
  z80_dp_pkg::byte_t m_shadow [z80_dp_pkg::NUM_MAIN_REGS];
  z80_dp_pkg::byte_t m_a;
  z80_dp_pkg::byte_t m_f;

  z80_datapath u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------

  // the bus source follows the fixed driver order, pins when nobody drives
  function automatic z80_dp_pkg::byte_t bus_model();
    if (drive_a) return m_a;
    if (drive_reg) return m_main[rd_code];
    if (drive_f) return m_f;
    return data_in;
  endfunction

  // high register in the upper byte of each pair
  function automatic z80_dp_pkg::word_t pair_model();
    case (pair_code)
      z80_dp_pkg::PAIR_BC: return {m_main[z80_dp_pkg::REG_B], m_main[z80_dp_pkg::REG_C]};
      z80_dp_pkg::PAIR_DE: return {m_main[z80_dp_pkg::REG_D], m_main[z80_dp_pkg::REG_E]};
      z80_dp_pkg::PAIR_HL: return {m_main[z80_dp_pkg::REG_H], m_main[z80_dp_pkg::REG_L]};
      default: return 16'h0000;
    endcase
  endfunction

  // returns the flags in the upper byte and the result in the lower byte
  function automatic logic [15:0] alu_model(input z80_dp_pkg::byte_t a,
      input z80_dp_pkg::byte_t b, input z80_dp_pkg::alu_op_t op, input z80_dp_pkg::byte_t f);
    int cin;
    int sum;
    int ssum;
    z80_dp_pkg::byte_t r;
    z80_dp_pkg::byte_t fl;
    fl = f;
    r = b;
    cin = (op == z80_dp_pkg::ALU_ADC) ? int'(f[z80_dp_pkg::FLAG_C]) : 0;
    case (op)
      z80_dp_pkg::ALU_ADD, z80_dp_pkg::ALU_ADC: begin
        sum = int'(a) + int'(b) + cin;
        // overflow is judged on the true signed sum
        ssum = int'($signed(a)) + int'($signed(b)) + cin;
        r = 8'(sum);
        fl[z80_dp_pkg::FLAG_H] = (int'(a[3:0]) + int'(b[3:0]) + cin) > 15;
        fl[z80_dp_pkg::FLAG_C] = sum > 255;
        fl[z80_dp_pkg::FLAG_PV] = (ssum > 127) || (ssum < -128);
        fl[z80_dp_pkg::FLAG_N] = 1'b0;
      end
      z80_dp_pkg::ALU_SUB: begin
        sum = int'(a) - int'(b);
        ssum = int'($signed(a)) - int'($signed(b));
        r = 8'(sum);
        fl[z80_dp_pkg::FLAG_H] = int'(a[3:0]) < int'(b[3:0]);
        fl[z80_dp_pkg::FLAG_C] = sum < 0;
        fl[z80_dp_pkg::FLAG_PV] = (ssum > 127) || (ssum < -128);
        fl[z80_dp_pkg::FLAG_N] = 1'b1;
      end
      z80_dp_pkg::ALU_AND, z80_dp_pkg::ALU_OR: begin
        r = (op == z80_dp_pkg::ALU_AND) ? (a & b) : (a | b);
        fl[z80_dp_pkg::FLAG_H] = (op == z80_dp_pkg::ALU_AND);
        fl[z80_dp_pkg::FLAG_C] = 1'b0;
        fl[z80_dp_pkg::FLAG_PV] = ($countones(r) % 2) == 0;
        fl[z80_dp_pkg::FLAG_N] = 1'b0;
      end
      z80_dp_pkg::ALU_INC: begin
        // carry is left alone by an increment
        r = b + 8'd1;
        fl[z80_dp_pkg::FLAG_H] = (int'(b[3:0]) + 1) > 15;
        fl[z80_dp_pkg::FLAG_PV] = (r == 8'h80);
        fl[z80_dp_pkg::FLAG_N] = 1'b0;
      end
      default: begin
      end
    endcase
    if (op != z80_dp_pkg::ALU_PASS) begin
      fl[z80_dp_pkg::FLAG_S] = r[7];
      fl[z80_dp_pkg::FLAG_Z] = (r == 8'h00);
    end
    return {fl, r};
  endfunction

  // state moves on the same edge as the DUT, from inputs held since the falling edge
  always @(posedge clk) begin
    z80_dp_pkg::byte_t bus;
    z80_dp_pkg::byte_t tmp;
    logic [15:0] alu;
    bus = bus_model();
    alu = alu_model(m_a, bus, alu_op, m_f);
    if (rst) begin
      for (int i = 0; i < z80_dp_pkg::NUM_MAIN_REGS; i++) begin
        m_main[i] = 8'h00;
        m_shadow[i] = 8'h00;
      end
      m_a = 8'h00;
      m_f = 8'h00;
    end else begin
      if (exx) begin
        for (int i = 0; i < z80_dp_pkg::NUM_MAIN_REGS; i++) begin
          tmp = m_main[i];
          m_main[i] = m_shadow[i];
          m_shadow[i] = tmp;
        end
      end else if (ld_reg) begin
        m_main[wr_code] = alu_to_reg ? alu[7:0] : bus;
      end
      if (ld_a) begin
        m_a = alu_to_a ? alu[7:0] : bus;
      end
      if (ld_f || (|flag_set) || (|flag_clr)) begin
        m_f = ((ld_f ? alu[15:8] : m_f) & ~flag_clr) | flag_set;
      end
    end
  end

  // --------------------------------------------------------------------------
  // checks and stimulus
  // --------------------------------------------------------------------------

  task automatic compare_outputs();
    z80_dp_pkg::byte_t exp_data;
    z80_dp_pkg::word_t exp_addr;
    exp_data = bus_model();
    exp_addr = pair_model();
    checks++;
    assert (data_out === exp_data) else begin
      errors++;
      $display("FAILED data_out expected %h got %h", exp_data, data_out);
    end
    assert (data_oe === (drive_a | drive_reg | drive_f)) else begin
      errors++;
      $display("FAILED data_oe expected %h got %h", drive_a | drive_reg | drive_f, data_oe);
    end
    assert (addr_out === exp_addr) else begin
      errors++;
      $display("FAILED addr_out expected %h got %h", exp_addr, addr_out);
    end
    assert (addr_oe === drive_pair) else begin
      errors++;
      $display("FAILED addr_oe expected %h got %h", drive_pair, addr_oe);
    end
  endtask

  // right after reset the pins are released and every register reads zero
  task automatic check_reset_state();
    checks++;
    assert (data_oe === 1'b0) else begin
      errors++;
      $display("FAILED data_oe expected %h got %h", 1'b0, data_oe);
    end
    assert (addr_oe === 1'b0) else begin
      errors++;
      $display("FAILED addr_oe expected %h got %h", 1'b0, addr_oe);
    end
    // main registers in code order, then A, then F, with a pair on the address bus
    for (int i = 0; i < RESET_READS; i++) begin
      rd_code = 3'(i % z80_dp_pkg::NUM_MAIN_REGS);
      pair_code = 2'(i % 3);
      drive_reg = (i < z80_dp_pkg::NUM_MAIN_REGS);
      drive_a = (i == z80_dp_pkg::NUM_MAIN_REGS);
      drive_f = (i == z80_dp_pkg::NUM_MAIN_REGS + 1);
      drive_pair = 1'b1;
      @(negedge clk);
      compare_outputs();
      assert (data_out === 8'h00) else begin
        errors++;
        $display("FAILED data_out expected %h got %h", 8'h00, data_out);
      end
      assert (addr_out === 16'h0000) else begin
        errors++;
        $display("FAILED addr_out expected %h got %h", 16'h0000, addr_out);
      end
    end
    {drive_reg, drive_a, drive_f, drive_pair} = '0;
  endtask

  // one bus driver at most, legal codes, no exx with a write, disjoint masks
  task automatic drive_random();
    int sel;
    sel = $unsigned($random(seed)) % 4;
    drive_a = (sel == 1);
    drive_reg = (sel == 2);
    drive_f = (sel == 3);
    {ld_a, alu_to_a, ld_f, alu_to_reg, drive_pair, ld_reg} = 6'($random(seed));
    exx = ($random(seed) % 16) == 0;
    ld_reg = ld_reg & ~exx;
    data_in = 8'($random(seed));
    wr_code = 3'($unsigned($random(seed)) % 6);
    rd_code = 3'($unsigned($random(seed)) % 6);
    pair_code = 2'($unsigned($random(seed)) % 3);
    alu_op = 3'($unsigned($random(seed)) % 7);
    // masks stay quiet most cycles so F mostly follows the ALU
    flag_set = (($random(seed) % 4) == 0) ? 8'($random(seed)) : 8'h00;
    flag_clr = (($random(seed) % 4) == 0) ? (8'($random(seed)) & ~flag_set) : 8'h00;
  endtask

  initial begin
    rst = 1'b1;
    {ld_reg, drive_reg, drive_pair, exx, ld_a, drive_a, ld_f, drive_f} = '0;
    {alu_to_a, alu_to_reg, data_in, flag_set, flag_clr} = '0;
    {wr_code, rd_code, pair_code, alu_op} = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    // each random cycle is checked before the next stimulus goes in
    repeat (RAND_CYCLES) begin
      @(negedge clk);
      compare_outputs();
      drive_random();
    end
    @(negedge clk);
    compare_outputs();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* files.f */
logic/z80_dp_pkg.sv
logic/regfile_if.sv
logic/z80_regfile.sv
logic/z80_alu.sv
logic/z80_acc_flags.sv
logic/z80_datapath.sv
dv/tb_z80_datapath.sv

/* logic/regfile_if.sv */
`timescale 1ns/1ns

// bundle between the datapath top and the register file
interface regfile_if;

  // byte write, at most one register per cycle
  logic                   wr_en;
  z80_dp_pkg::reg_code_t  wr_code;
  z80_dp_pkg::byte_t      wr_data;

  // byte read and pair read, both combinational and always valid
  z80_dp_pkg::reg_code_t  rd_code;
  z80_dp_pkg::byte_t      rd_data;
  z80_dp_pkg::pair_code_t pair_code;
  z80_dp_pkg::word_t      pair_data;

  // swap of the whole main bank with the shadow bank
  logic                   exx;

  // the top level steers the file
  modport core (output wr_en, wr_code, wr_data, rd_code, pair_code, exx,
                input  rd_data, pair_data);

  // the register file answers reads and takes writes
  modport file (input  wr_en, wr_code, wr_data, rd_code, pair_code, exx,
                output rd_data, pair_data);

endinterface

/* logic/z80_acc_flags.sv */
`timescale 1ns/1ns

module z80_acc_flags (
  input  logic              clk,
  input  logic              rst,
  input  z80_dp_pkg::byte_t bus,
  input  z80_dp_pkg::byte_t alu_result,
  input  z80_dp_pkg::byte_t alu_flags,
  input  logic              ld_a,
  input  logic              alu_to_a,
  input  logic              ld_f,
  input  z80_dp_pkg::byte_t flag_set,
  input  z80_dp_pkg::byte_t flag_clr,
  output z80_dp_pkg::byte_t a,
  output z80_dp_pkg::byte_t f
);

  // base value for F before the override masks are applied
  z80_dp_pkg::byte_t f_base;
  z80_dp_pkg::byte_t f_next;
  // F moves on an alu load or on any forced bit
  logic              f_upd;

  assign f_base = ld_f ? alu_flags : f;
  // clear first, then set, so a set bit always wins in the final value
  assign f_next = (f_base & ~flag_clr) | flag_set;
  assign f_upd  = ld_f | (|flag_set) | (|flag_clr);

  // --------------------------------------------------------------------------
  // accumulator and flag registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      a <= '0;
      f <= '0;
    end else begin
      // the alu result reaches A point to point, leaving the bus free
      if (ld_a) begin
        a <= alu_to_a ? alu_result : bus;
      end
      if (f_upd) begin
        f <= f_next;
      end
    end
  end

  // a bit in both masks would depend on the order of the override
  a_masks_disjoint : assert property (@(posedge clk) disable iff (rst)
    (flag_set & flag_clr) == 8'h00);

endmodule

/* logic/z80_alu.sv */
`timescale 1ns/1ns

module z80_alu (
  input  z80_dp_pkg::byte_t   a,
  input  z80_dp_pkg::byte_t   b,
  input  z80_dp_pkg::alu_op_t op,
  input  z80_dp_pkg::byte_t   flags_in,
  output z80_dp_pkg::byte_t   result,
  output z80_dp_pkg::byte_t   flags_out
);

  // --------------------------------------------------------------------------
  // adders
  // --------------------------------------------------------------------------

  // carry in only counts for adc
  logic       carry_in;
  // nine bit sums keep the carry or borrow out of bit 7
  logic [8:0] add_full;
  logic [8:0] sub_full;
  // five bit nibble sums give the half carry and half borrow
  logic [4:0] add_low;
  logic [4:0] sub_low;
  z80_dp_pkg::byte_t inc_res;
  // S and Z follow the result for every op that is not a pass
  logic       sz_update;

  assign carry_in = (op == z80_dp_pkg::ALU_ADC) & flags_in[z80_dp_pkg::FLAG_C];
  assign add_full = {1'b0, a} + {1'b0, b} + {8'b0, carry_in};
  assign add_low  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, carry_in};
  assign sub_full = {1'b0, a} - {1'b0, b};
  assign sub_low  = {1'b0, a[3:0]} - {1'b0, b[3:0]};
  assign inc_res  = b + 8'd1;

  // --------------------------------------------------------------------------
  // result and flags
  // --------------------------------------------------------------------------

  always_comb begin
    // bits 5 and 3, and any flag an op leaves alone, keep the old value
    flags_out = flags_in;
    result    = b;
    sz_update = 1'b1;

    case (op)
      z80_dp_pkg::ALU_ADD, z80_dp_pkg::ALU_ADC: begin
        result = add_full[7:0];
        flags_out[z80_dp_pkg::FLAG_H] = add_low[4];
        flags_out[z80_dp_pkg::FLAG_C] = add_full[8];
        // overflow when both operands share a sign the result does not
        flags_out[z80_dp_pkg::FLAG_PV] = (a[7] == b[7]) && (add_full[7] != a[7]);
        flags_out[z80_dp_pkg::FLAG_N] = 1'b0;
      end
      z80_dp_pkg::ALU_SUB: begin
        result = sub_full[7:0];
        // the top bit of each difference is the borrow out of that field
        flags_out[z80_dp_pkg::FLAG_H] = sub_low[4];
        flags_out[z80_dp_pkg::FLAG_C] = sub_full[8];
        // overflow when the signs differ and the result flips away from a
        flags_out[z80_dp_pkg::FLAG_PV] = (a[7] != b[7]) && (sub_full[7] != a[7]);
        flags_out[z80_dp_pkg::FLAG_N] = 1'b1;
      end
      z80_dp_pkg::ALU_AND: begin
        result = a & b;
        flags_out[z80_dp_pkg::FLAG_H]  = 1'b1;
        flags_out[z80_dp_pkg::FLAG_C]  = 1'b0;
        flags_out[z80_dp_pkg::FLAG_PV] = ~^(a & b);
        flags_out[z80_dp_pkg::FLAG_N]  = 1'b0;
      end
      z80_dp_pkg::ALU_OR: begin
        result = a | b;
        flags_out[z80_dp_pkg::FLAG_H]  = 1'b0;
        flags_out[z80_dp_pkg::FLAG_C]  = 1'b0;
        flags_out[z80_dp_pkg::FLAG_PV] = ~^(a | b);
        flags_out[z80_dp_pkg::FLAG_N]  = 1'b0;
      end
      z80_dp_pkg::ALU_INC: begin
        // increment works on the bus operand so registers can count in place
        result = inc_res;
        flags_out[z80_dp_pkg::FLAG_H]  = (b[3:0] == 4'hf);
        flags_out[z80_dp_pkg::FLAG_PV] = (inc_res == 8'h80);
        flags_out[z80_dp_pkg::FLAG_N]  = 1'b0;
      end
      default: begin
        // pass, and the unused code 7, move b through untouched
        sz_update = 1'b0;
      end
    endcase

    if (sz_update) begin
      flags_out[z80_dp_pkg::FLAG_S] = result[7];
      flags_out[z80_dp_pkg::FLAG_Z] = (result == 8'h00);
    end
  end

endmodule

/* logic/z80_datapath.sv */
`timescale 1ns/1ns

module z80_datapath (
  input  logic                   clk,
  input  logic                   rst,
  input  z80_dp_pkg::byte_t      data_in,
  output z80_dp_pkg::byte_t      data_out,
  output logic                   data_oe,
  output z80_dp_pkg::word_t      addr_out,
  output logic                   addr_oe,
  input  logic                   ld_reg,
  input  logic                   drive_reg,
  input  z80_dp_pkg::reg_code_t  wr_code,
  input  z80_dp_pkg::reg_code_t  rd_code,
  input  z80_dp_pkg::pair_code_t pair_code,
  input  logic                   drive_pair,
  input  logic                   exx,
  input  logic                   ld_a,
  input  logic                   drive_a,
  input  logic                   ld_f,
  input  logic                   drive_f,
  input  z80_dp_pkg::alu_op_t    alu_op,
  input  logic                   alu_to_a,
  input  logic                   alu_to_reg,
  input  z80_dp_pkg::byte_t      flag_set,
  input  z80_dp_pkg::byte_t      flag_clr
);

  // internal data bus, shared by every source and sink in the datapath
  z80_dp_pkg::byte_t int_bus;
  z80_dp_pkg::byte_t a_q;
  z80_dp_pkg::byte_t f_q;
  z80_dp_pkg::byte_t alu_result;
  z80_dp_pkg::byte_t alu_flags;

  regfile_if rf_bus ();

  // --------------------------------------------------------------------------
  // data bus arbitration
  // --------------------------------------------------------------------------

  // fixed priority, though the controller only ever raises one driver
  always_comb begin
    if (drive_a) begin
      int_bus = a_q;
    end else if (drive_reg) begin
      int_bus = rf_bus.rd_data;
    end else if (drive_f) begin
      int_bus = f_q;
    end else begin
      // nobody inside drives, so the bus listens to the pins
      int_bus = data_in;
    end
  end

  // output enables replace a tristate on the pins
  assign data_out = int_bus;
  assign data_oe  = drive_a | drive_reg | drive_f;
  assign addr_out = rf_bus.pair_data;
  assign addr_oe  = drive_pair;

  // --------------------------------------------------------------------------
  // register file
  // --------------------------------------------------------------------------

  assign rf_bus.wr_en     = ld_reg;
  assign rf_bus.wr_code   = wr_code;
  // increments come back point to point while the register drives the bus
  assign rf_bus.wr_data   = alu_to_reg ? alu_result : int_bus;
  assign rf_bus.rd_code   = rd_code;
  assign rf_bus.pair_code = pair_code;
  assign rf_bus.exx       = exx;

  z80_regfile u_regfile (
    .clk (clk),
    .rst (rst),
    .rf  (rf_bus)
  );

  // --------------------------------------------------------------------------
  // alu, accumulator and flags
  // --------------------------------------------------------------------------

  z80_alu u_alu (
    .a         (a_q),
    .b         (int_bus),
    .op        (alu_op),
    .flags_in  (f_q),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  z80_acc_flags u_acc_flags (
    .clk        (clk),
    .rst        (rst),
    .bus        (int_bus),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .ld_a       (ld_a),
    .alu_to_a   (alu_to_a),
    .ld_f       (ld_f),
    .flag_set   (flag_set),
    .flag_clr   (flag_clr),
    .a          (a_q),
    .f          (f_q)
  );

  // two drivers at once would hide one of them behind the priority mux
  a_one_driver : assert property (@(posedge clk) disable iff (rst)
    $onehot0({drive_a, drive_reg, drive_f}));

endmodule

/* logic/z80_dp_pkg.sv */
package z80_dp_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------

  // the datapath moves bytes on the data bus and words on the address bus
  localparam int BYTE_W = 8;
  localparam int WORD_W = 16;

  // six main registers, each with a shadow copy swapped by exx
  localparam int NUM_MAIN_REGS = 6;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [2:0]        reg_code_t;
  typedef logic [1:0]        pair_code_t;
  typedef logic [2:0]        alu_op_t;

  // --------------------------------------------------------------------------
  // register and pair codes
  // --------------------------------------------------------------------------

  // codes 6 and 7 name no register
  localparam reg_code_t REG_B = 3'd0;
  localparam reg_code_t REG_C = 3'd1;
  localparam reg_code_t REG_D = 3'd2;
  localparam reg_code_t REG_E = 3'd3;
  localparam reg_code_t REG_H = 3'd4;
  localparam reg_code_t REG_L = 3'd5;

  // a pair is the high register followed by the low register, code 3 unused
  localparam pair_code_t PAIR_BC = 2'd0;
  localparam pair_code_t PAIR_DE = 2'd1;
  localparam pair_code_t PAIR_HL = 2'd2;

  // --------------------------------------------------------------------------
  // alu opcodes and flag positions
  // --------------------------------------------------------------------------

  localparam alu_op_t ALU_ADD  = 3'd0;
  localparam alu_op_t ALU_ADC  = 3'd1;
  localparam alu_op_t ALU_SUB  = 3'd2;
  localparam alu_op_t ALU_AND  = 3'd3;
  localparam alu_op_t ALU_OR   = 3'd4;
  localparam alu_op_t ALU_INC  = 3'd5;
  localparam alu_op_t ALU_PASS = 3'd6;

  // bits 5 and 3 of F are undocumented and simply hold their value
  localparam int FLAG_S  = 7;
  localparam int FLAG_Z  = 6;
  localparam int FLAG_H  = 4;
  localparam int FLAG_PV = 2;
  localparam int FLAG_N  = 1;
  localparam int FLAG_C  = 0;

endpackage

/* logic/z80_regfile.sv */
`timescale 1ns/1ns

module z80_regfile (
  input logic    clk,
  input logic    rst,
  regfile_if.file rf
);

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------

  // main bank is indexed by the register code, so B sits at 0 and L at 5
  z80_dp_pkg::byte_t main_q   [z80_dp_pkg::NUM_MAIN_REGS];
  // shadow bank mirrors the same order, only exx reaches it
  z80_dp_pkg::byte_t shadow_q [z80_dp_pkg::NUM_MAIN_REGS];

  // exx wins over a byte write, the controller never asks for both
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < z80_dp_pkg::NUM_MAIN_REGS; i++) begin
        main_q[i]   <= '0;
        shadow_q[i] <= '0;
      end
    end else if (rf.exx) begin
      // every register trades places with its shadow on the same edge
      for (int i = 0; i < z80_dp_pkg::NUM_MAIN_REGS; i++) begin
        main_q[i]   <= shadow_q[i];
        shadow_q[i] <= main_q[i];
      end
    end else if (rf.wr_en) begin
      main_q[rf.wr_code] <= rf.wr_data;
    end
  end

  // --------------------------------------------------------------------------
  // read ports
  // --------------------------------------------------------------------------

  // byte read follows rd_code in the same cycle
  always_comb begin
    if (rf.rd_code < z80_dp_pkg::NUM_MAIN_REGS) begin
      rf.rd_data = main_q[rf.rd_code];
    end else begin
      // illegal codes read as zero rather than x
      rf.rd_data = '0;
    end
  end

  // pair read puts the high register in the upper byte
  always_comb begin
    case (rf.pair_code)
      z80_dp_pkg::PAIR_BC: begin
        rf.pair_data = {main_q[z80_dp_pkg::REG_B], main_q[z80_dp_pkg::REG_C]};
      end
      z80_dp_pkg::PAIR_DE: begin
        rf.pair_data = {main_q[z80_dp_pkg::REG_D], main_q[z80_dp_pkg::REG_E]};
      end
      z80_dp_pkg::PAIR_HL: begin
        rf.pair_data = {main_q[z80_dp_pkg::REG_H], main_q[z80_dp_pkg::REG_L]};
      end
      default: begin
        rf.pair_data = '0;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // checks on the controller
  // --------------------------------------------------------------------------

  // a write to code 6 or 7 would be dropped silently
  a_wr_code_legal : assert property (@(posedge clk) disable iff (rst)
    rf.wr_en |-> (rf.wr_code < z80_dp_pkg::NUM_MAIN_REGS));

  // the read code steers the data bus whenever the top drives it
  a_rd_code_legal : assert property (@(posedge clk) disable iff (rst)
    rf.rd_code < z80_dp_pkg::NUM_MAIN_REGS);

  // pair code 3 would put zero on the address bus
  a_pair_code_legal : assert property (@(posedge clk) disable iff (rst)
    rf.pair_code != 2'd3);

  // a write in the same cycle as exx would be lost
  a_exx_no_write : assert property (@(posedge clk) disable iff (rst)
    !(rf.exx && rf.wr_en));

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_z80_datapath -o sim_z80 \
  && ./obj_dir/sim_z80 | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
  && echo "simulation run ok" \
  || { echo "simulation run not ok"; exit 1; }
